// File: Makefile
# Verilator flow for the ifetch fetch stage
TOP = ifetch_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f ifetch.f --top-module $(TOP)

# Pass only if the testbench printed its pass line
sim:
	verilator --binary --timing -Wno-fatal -f ifetch.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: dv/ifetch_clkgen.sv
// Clock and reset source for the ifetch testbench.
// Makes a 20 ns clock and holds reset_n low for five rising edges,
// releasing it halfway through the high phase.

`timescale 1ns/1ns

module ifetch_clkgen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge clk);
        #5 reset_n = 1'b1;
    end

endmodule

// File: dv/ifetch_tb.sv
// Testbench for the ifetch instruction fetch stage.
// Drives random stalls, redirects and soft resets from an LFSR on the
// falling edge, models a synchronous memory with one cycle of latency,
// steps a cycle-level reference after each rising edge and compares
// every output of the stage before the next stimulus is applied.

`timescale 1ns/1ns

`include "ifetch_cfg.svh"

module ifetch_tb;

    import ifetch_pkg::*;

    localparam int                      NUM_CYCLES     = 2000;
    localparam int                      TIMEOUT_CYCLES = 2500;
    localparam logic [`IFETCH_XLEN-1:0] MEM_PATTERN    = 32'hA5A5_0000;

    logic                    clk;
    logic                    reset_n;
    logic                    sys_reset;
    logic                    enable;
    redirect_req_t           redir;
    logic [`IFETCH_XLEN-1:0] imem_addr;
    logic [`IFETCH_XLEN-1:0] imem_data = 32'd0;
    decode_out_t             dec;
    logic [15:0]             lfsr;

    // Reference model state
    logic [`IFETCH_XLEN-1:0] exp_addr;
    logic [`IFETCH_XLEN-1:0] exp_rb_addr;
    logic [`IFETCH_XLEN-1:0] exp_mem;
    logic [`IFETCH_XLEN-1:0] exp_held;
    logic [`IFETCH_XLEN-1:0] exp_pc_jump;
    logic [`IFETCH_XLEN-1:0] exp_pc;
    logic [`IFETCH_XLEN-1:0] exp_instr;
    logic                    exp_en_r;
    logic                    exp_jump_pend;
    logic                    exp_jumping;
    logic                    exp_rb_pend;
    logic                    exp_bp_rb;

    ifetch_clkgen u_clkgen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    ifetch_top uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .sys_reset_i (sys_reset),
        .enable_i    (enable),
        .redir_i     (redir),
        .imem_data_i (imem_data),
        .imem_addr_o (imem_addr),
        .dec_o       (dec)
    );

    // Synchronous instruction memory returning the address XORed with a fixed pattern
    always @(posedge clk) begin
        imem_data <= imem_addr ^ MEM_PATTERN;
    end

    //////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////

    // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] bits;
        bits = 32'd0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return bits;
    endfunction

    task automatic drive_inputs();
        enable            = (next_bits(2) != 32'd0);
        sys_reset         = (next_bits(6) == 32'd0);
        redir.ctx_switch  = (next_bits(4) == 32'd0);
        redir.jump        = (next_bits(4) == 32'd0);
        redir.bp_take     = (next_bits(4) == 32'd0);
        redir.rollback    = (next_bits(4) == 32'd0);
        redir.ctx_target  = next_bits(32);
        redir.jump_target = next_bits(32);
        redir.bp_target   = next_bits(32);
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Power-on reset values with the start word already on the memory bus
    task automatic init_model();
        exp_addr      = `IFETCH_START_ADDR;
        exp_rb_addr   = 32'd0;
        exp_mem       = `IFETCH_START_ADDR ^ MEM_PATTERN;
        exp_held      = `IFETCH_NOP;
        exp_pc_jump   = 32'd0;
        exp_pc        = 32'd0;
        exp_instr     = `IFETCH_NOP;
        exp_en_r      = 1'b0;
        exp_jump_pend = 1'b1;
        exp_jumping   = 1'b1;
        exp_rb_pend   = 1'b0;
        exp_bp_rb     = 1'b0;
    endtask

    // One rising edge where old values are read before they are replaced
    task automatic advance_model();
        logic                    take_ctx;
        logic                    take_jump;
        logic                    take_rb;
        logic                    take_bp;
        logic                    jumped;
        logic [`IFETCH_XLEN-1:0] fetched;
        logic [`IFETCH_XLEN-1:0] next_addr;

        take_ctx  = redir.ctx_switch;
        take_jump = !take_ctx && redir.jump;
        take_rb   = !take_ctx && !take_jump && redir.rollback;
        take_bp   = !take_ctx && !take_jump && !take_rb && redir.bp_take && enable;
        jumped    = take_ctx || take_jump || take_bp;

        next_addr = sys_reset ? `IFETCH_START_ADDR :
                    take_ctx  ? {redir.ctx_target[31:2], 2'b00} :
                    take_jump ? {redir.jump_target[31:2], 2'b00} :
                    take_rb   ? exp_rb_addr :
                    take_bp   ? {redir.bp_target[31:2], 2'b00} :
                    enable    ? exp_addr + 32'd4 : exp_addr;

        // Data path with the stall copy
        fetched   = exp_en_r ? exp_mem : exp_held;
        exp_instr = sys_reset ? `IFETCH_NOP : (enable ? fetched : exp_instr);
        exp_held  = (!enable && exp_en_r) ? exp_mem : exp_held;
        exp_en_r  = enable;
        exp_mem   = exp_addr ^ MEM_PATTERN;

        // Two-stage pc behind the fetch address
        exp_pc      = enable ? exp_pc_jump : exp_pc;
        exp_pc_jump = (enable || exp_jump_pend) ? exp_addr : exp_pc_jump;
        exp_rb_addr = sys_reset ? 32'd0 :
                      (enable && redir.bp_take) ? exp_addr + 32'd4 : exp_rb_addr;
        exp_addr    = next_addr;

        // Flags toward decode
        exp_bp_rb     = !sys_reset && (enable ? exp_rb_pend : exp_bp_rb);
        exp_rb_pend   = !sys_reset && (take_rb || (exp_rb_pend && !enable));
        exp_jumping   = sys_reset || jumped || (exp_jump_pend && !take_rb) ||
                        (exp_jumping && !enable && !take_rb);
        exp_jump_pend = sys_reset || jumped || (exp_jump_pend && !enable && !take_rb);
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compare_outputs(input int cycle);
        expect_equal($sformatf("fetch address at cycle %0d", cycle), exp_addr, imem_addr);
        expect_equal($sformatf("decode instr at cycle %0d", cycle), exp_instr, dec.instr);
        expect_equal($sformatf("decode pc at cycle %0d", cycle), exp_pc, dec.pc);
        expect_equal($sformatf("jumping at cycle %0d", cycle),
                     32'(exp_jumping), 32'(dec.jumping));
        expect_equal($sformatf("bp_rollback at cycle %0d", cycle),
                     32'(exp_bp_rb), 32'(dec.bp_rollback));
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int cycle;
        int wait_cnt;
        sys_reset = 1'b0;
        enable    = 1'b0;
        redir     = '0;
        lfsr      = 16'd29040;
        init_model();

        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (reset_n !== 1'b1 && wait_cnt < 20);
        if (reset_n !== 1'b1) begin
            $display("Test failures found");
            $fatal(1, "reset was never released");
        end

        // Compare on the falling edge and drive the next cycle
        for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            compare_outputs(cycle);
            drive_inputs();
            @(posedge clk);
            advance_model();
            @(negedge clk);
        end
        compare_outputs(NUM_CYCLES);
        $display("All tests passed!");
        $finish;
    end

    // Watchdog
    initial begin : watchdog
        int n;
        for (n = 0; n < TIMEOUT_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("Test failures found");
        $fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end

endmodule

// File: ifetch.f
+incdir+include
logic/ifetch_pkg.sv
logic/ifetch_addr_gen.sv
logic/ifetch_flush_ctrl.sv
logic/ifetch_inst_reg.sv
logic/ifetch_top.sv
dv/ifetch_clkgen.sv
dv/ifetch_tb.sv

// File: include/ifetch_cfg.svh
// Configuration constants for the ifetch instruction fetch stage.
// Include this header in every file that needs the reset address,
// the NOP encoding or the address and instruction word width.

`ifndef IFETCH_CFG_SVH
`define IFETCH_CFG_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

// Address and instruction word width
`define IFETCH_XLEN 32

//////////////////////////////////////////////////
// Reset values
//////////////////////////////////////////////////

// First fetch address after reset or soft reset
`define IFETCH_START_ADDR 32'h0000_0100

// addi x0,x0,0
`define IFETCH_NOP 32'h0000_0013

`endif

// File: logic/ifetch_addr_gen.sv
// Fetch address generator.
// Picks the redirect with the highest priority, then builds the next
// word address from a target, the stored rollback address or the
// current address plus four. Owns the fetch address register and the
// rollback address captured when a branch prediction is taken.

`timescale 1ns/1ns

`include "ifetch_cfg.svh"

module ifetch_addr_gen (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       sys_reset_i,
    input  logic                       enable_i,
    input  ifetch_pkg::redirect_req_t  redir_i,
    output ifetch_pkg::redirect_kind_e kind_o,
    output logic [`IFETCH_XLEN-1:0]    imem_addr_o
);

    import ifetch_pkg::*;

    logic [`IFETCH_XLEN-1:2] addr_advance;
    logic [`IFETCH_XLEN-1:2] addr_next;
    logic [`IFETCH_XLEN-1:2] rollback_addr;
    logic                    addr_update;

    //////////////////////////////////////////////////
    // Redirect priority
    //////////////////////////////////////////////////

    // Context switch and jump act even while stalled
    always_comb begin
        if (redir_i.ctx_switch) begin
            kind_o = REDIR_CTX;
        end else if (redir_i.jump) begin
            kind_o = REDIR_JUMP;
        end else if (redir_i.rollback) begin
            kind_o = REDIR_ROLLBACK;
        end else if (redir_i.bp_take && enable_i) begin
            kind_o = REDIR_BP;
        end else begin
            kind_o = REDIR_NONE;
        end
    end

    //////////////////////////////////////////////////
    // Next word address
    //////////////////////////////////////////////////

    assign addr_advance = imem_addr_o[`IFETCH_XLEN-1:2] + 1'b1;

    // Word targets drop bits 1:0 without compressed support
    always_comb begin
        case (kind_o)
            REDIR_CTX:      addr_next = redir_i.ctx_target[`IFETCH_XLEN-1:2];
            REDIR_JUMP:     addr_next = redir_i.jump_target[`IFETCH_XLEN-1:2];
            REDIR_ROLLBACK: addr_next = rollback_addr;
            REDIR_BP:       addr_next = redir_i.bp_target[`IFETCH_XLEN-1:2];
            default:        addr_next = addr_advance;
        endcase
    end

    // Hold while stalled unless something redirects
    assign addr_update = enable_i || (kind_o != REDIR_NONE);

    //////////////////////////////////////////////////
    // Fetch address register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            imem_addr_o <= `IFETCH_START_ADDR;
        end else if (sys_reset_i) begin
            imem_addr_o <= `IFETCH_START_ADDR;
        end else if (addr_update) begin
            imem_addr_o <= {addr_next, 2'b00};
        end
    end

    //////////////////////////////////////////////////
    // Rollback address
    //////////////////////////////////////////////////

    // Word after the predicted instruction for a wrong guess
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rollback_addr <= '0;
        end else if (sys_reset_i) begin
            rollback_addr <= '0;
        end else if (enable_i && redir_i.bp_take) begin
            rollback_addr <= addr_advance;
        end
    end

endmodule

// File: logic/ifetch_flush_ctrl.sv
// Flush control for the fetch stage.
// Tracks whether a redirect is still in flight so decode can squash
// the bubble behind it, and raises a one-shot flag toward decode on
// the enabled edge that follows a branch rollback.

`timescale 1ns/1ns

module ifetch_flush_ctrl (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       sys_reset_i,
    input  logic                       enable_i,
    input  ifetch_pkg::redirect_kind_e kind_i,
    output logic                       jumped_r_o,
    output logic                       jumping_o,
    output logic                       bp_rollback_o
);

    import ifetch_pkg::*;

    logic jumped;
    logic rollback;
    logic rollback_pend;

    // Any redirect but a rollback starts a new bubble
    assign jumped   = (kind_i == REDIR_CTX) || (kind_i == REDIR_JUMP) || (kind_i == REDIR_BP);
    assign rollback = (kind_i == REDIR_ROLLBACK);

    //////////////////////////////////////////////////
    // Jump tracking
    //////////////////////////////////////////////////

    // Jump pending
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r_o <= 1'b1;
        end else if (sys_reset_i) begin
            jumped_r_o <= 1'b1;
        end else if (jumped) begin
            jumped_r_o <= 1'b1;
        end else if (enable_i || rollback) begin
            jumped_r_o <= 1'b0;
        end
    end

    // Stays high one more edge while the pending flag drains
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumping_o <= 1'b1;
        end else if (sys_reset_i) begin
            jumping_o <= 1'b1;
        end else if (jumped || (jumped_r_o && !rollback)) begin
            jumping_o <= 1'b1;
        end else if (enable_i || rollback) begin
            jumping_o <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Rollback flag
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rollback_pend <= 1'b0;
        end else if (sys_reset_i) begin
            rollback_pend <= 1'b0;
        end else if (rollback) begin
            rollback_pend <= 1'b1;
        end else if (enable_i) begin
            rollback_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bp_rollback_o <= 1'b0;
        end else if (sys_reset_i) begin
            bp_rollback_o <= 1'b0;
        end else if (enable_i) begin
            bp_rollback_o <= rollback_pend;
        end
    end

endmodule

// File: logic/ifetch_inst_reg.sv
// Instruction and pc registers of the fetch stage.
// The memory word arrives one cycle after its address; during a stall
// the word that was on the bus is latched and replayed. The pc follows
// the fetch address through two registers so it lines up with the
// instruction handed to decode.

`timescale 1ns/1ns

`include "ifetch_cfg.svh"

module ifetch_inst_reg (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sys_reset_i,
    input  logic                    enable_i,
    input  logic                    jumped_r_i,
    input  logic [`IFETCH_XLEN-1:0] imem_addr_i,
    input  logic [`IFETCH_XLEN-1:0] imem_data_i,
    output logic [`IFETCH_XLEN-1:0] instr_o,
    output logic [`IFETCH_XLEN-1:0] pc_o
);

    logic                    enable_r;
    logic [`IFETCH_XLEN-1:0] data_held;
    logic [`IFETCH_XLEN-1:0] data_fetched;
    logic [`IFETCH_XLEN-1:0] pc_jump_r;

    //////////////////////////////////////////////////
    // Stall hold
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_r <= 1'b0;
        end else begin
            enable_r <= enable_i;
        end
    end

    // Capture the bus on the first stalled edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_held <= `IFETCH_NOP;
        end else if (!enable_i && enable_r) begin
            data_held <= imem_data_i;
        end
    end

    assign data_fetched = enable_r ? imem_data_i : data_held;

    //////////////////////////////////////////////////
    // PC pipeline
    //////////////////////////////////////////////////

    // Also loads while a jump is pending so the target is not lost
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_jump_r <= '0;
        end else if (enable_i || jumped_r_i) begin
            pc_jump_r <= imem_addr_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o <= '0;
        end else if (enable_i) begin
            pc_o <= pc_jump_r;
        end
    end

    //////////////////////////////////////////////////
    // Instruction to decode
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_o <= `IFETCH_NOP;
        end else if (sys_reset_i) begin
            instr_o <= `IFETCH_NOP;
        end else if (enable_i) begin
            instr_o <= data_fetched;
        end
    end

endmodule

// File: logic/ifetch_pkg.sv
// Shared types for the ifetch instruction fetch stage.
// Holds the redirect request taken from the later pipeline stages,
// the redirect kind picked each cycle and the bundle handed to decode.
// Modules import it inside their bodies and use scoped names in ports.

`include "ifetch_cfg.svh"

package ifetch_pkg;

    //////////////////////////////////////////////////
    // Redirect inputs
    //////////////////////////////////////////////////

    // Strobes and targets from execute, CSR and predictor
    typedef struct packed {
        logic                    ctx_switch;
        logic                    jump;
        logic                    bp_take;
        logic                    rollback;
        logic [`IFETCH_XLEN-1:0] ctx_target;
        logic [`IFETCH_XLEN-1:0] jump_target;
        logic [`IFETCH_XLEN-1:0] bp_target;
    } redirect_req_t;

    // Redirect selected this cycle after priority
    typedef enum logic [2:0] {
        REDIR_NONE     = 3'd0,
        REDIR_CTX      = 3'd1,
        REDIR_JUMP     = 3'd2,
        REDIR_BP       = 3'd3,
        REDIR_ROLLBACK = 3'd4
    } redirect_kind_e;

    //////////////////////////////////////////////////
    // Decode side
    //////////////////////////////////////////////////

    // Everything the fetch stage presents to decode
    typedef struct packed {
        logic [`IFETCH_XLEN-1:0] instr;
        logic [`IFETCH_XLEN-1:0] pc;
        logic                    jumping;
        logic                    bp_rollback;
    } decode_out_t;

endpackage

// File: logic/ifetch_top.sv
// Top level of the ifetch instruction fetch stage.
// Connects the address generator, the flush control and the
// instruction registers, and gathers their outputs for decode.
// Expects a synchronous instruction memory with one cycle of latency.

`timescale 1ns/1ns

`include "ifetch_cfg.svh"

module ifetch_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      sys_reset_i,
    input  logic                      enable_i,
    input  ifetch_pkg::redirect_req_t redir_i,
    input  logic [`IFETCH_XLEN-1:0]   imem_data_i,
    output logic [`IFETCH_XLEN-1:0]   imem_addr_o,
    output ifetch_pkg::decode_out_t   dec_o
);

    ifetch_pkg::redirect_kind_e kind;
    logic                       jumped_r;
    logic                       jumping;
    logic                       bp_rollback;
    logic [`IFETCH_XLEN-1:0]    instr;
    logic [`IFETCH_XLEN-1:0]    pc;

    ifetch_addr_gen u_addr_gen (
        .clk         (clk),
        .reset_n     (reset_n),
        .sys_reset_i (sys_reset_i),
        .enable_i    (enable_i),
        .redir_i     (redir_i),
        .kind_o      (kind),
        .imem_addr_o (imem_addr_o)
    );

    ifetch_flush_ctrl u_flush_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .sys_reset_i   (sys_reset_i),
        .enable_i      (enable_i),
        .kind_i        (kind),
        .jumped_r_o    (jumped_r),
        .jumping_o     (jumping),
        .bp_rollback_o (bp_rollback)
    );

    ifetch_inst_reg u_inst_reg (
        .clk         (clk),
        .reset_n     (reset_n),
        .sys_reset_i (sys_reset_i),
        .enable_i    (enable_i),
        .jumped_r_i  (jumped_r),
        .imem_addr_i (imem_addr_o),
        .imem_data_i (imem_data_i),
        .instr_o     (instr),
        .pc_o        (pc)
    );

    // Decode bundle
    assign dec_o = '{instr: instr, pc: pc, jumping: jumping, bp_rollback: bp_rollback};

endmodule
